/* hdl/core_ctrl_pkg.sv */
//////////////////////////////
// shared widths, privilege and pc select
// types, mcause codes and controller states
//////////////////////////////

package core_ctrl_pkg;

  // datapath word width
  localparam int unsigned XLEN         = 32;
  // fast interrupt lines and their index width
  localparam int unsigned NUM_FAST_IRQ = 15;
  localparam int unsigned FAST_ID_W    = 4;

  // privilege level, only U and M are implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // fetch address select towards the IF stage
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_EXC  = 2'b10,
    PC_ERET = 2'b11
  } pc_sel_e;

  // mcause value, bit 5 flags an interrupt
  typedef enum logic [5:0] {
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'h05,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07,
    EXC_CAUSE_ECALL_UMODE        = 6'h08,
    EXC_CAUSE_ECALL_MMODE        = 6'h0B,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'h23,
    EXC_CAUSE_IRQ_TIMER_M        = 6'h27,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'h2B,
    // fast interrupt n sits at 0x30 + n
    EXC_CAUSE_IRQ_FAST_0         = 6'h30,
    EXC_CAUSE_IRQ_FAST_1         = 6'h31,
    EXC_CAUSE_IRQ_FAST_2         = 6'h32,
    EXC_CAUSE_IRQ_FAST_3         = 6'h33,
    EXC_CAUSE_IRQ_FAST_4         = 6'h34,
    EXC_CAUSE_IRQ_FAST_5         = 6'h35,
    EXC_CAUSE_IRQ_FAST_6         = 6'h36,
    EXC_CAUSE_IRQ_FAST_7         = 6'h37,
    EXC_CAUSE_IRQ_FAST_8         = 6'h38,
    EXC_CAUSE_IRQ_FAST_9         = 6'h39,
    EXC_CAUSE_IRQ_FAST_10        = 6'h3A,
    EXC_CAUSE_IRQ_FAST_11        = 6'h3B,
    EXC_CAUSE_IRQ_FAST_12        = 6'h3C,
    EXC_CAUSE_IRQ_FAST_13        = 6'h3D,
    EXC_CAUSE_IRQ_FAST_14        = 6'h3E,
    EXC_CAUSE_IRQ_NM             = 6'h3F
  } exc_cause_e;

  // main controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

endpackage

/* hdl/core_ctrl_exc.sv */
//////////////////////////////
// synchronous exception unit: flag
// qualification, request registers, priority
//////////////////////////////

`timescale 1ns/1ps

module core_ctrl_exc import core_ctrl_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   instr_valid_i,
  input  logic                   illegal_insn_i,
  input  logic                   ecall_insn_i,
  input  logic                   ebrk_insn_i,
  input  logic                   mret_insn_i,
  input  logic                   wfi_insn_i,
  input  logic                   csr_pipe_flush_i,
  input  logic                   instr_fetch_err_i,
  input  logic                   instr_fetch_err_plus2_i,
  input  priv_lvl_e              priv_mode_i,
  input  logic                   csr_mstatus_tw_i,
  input  logic                   load_err_i,
  input  logic                   store_err_i,
  input  logic [XLEN-1:0]        instr_i,
  input  logic [15:0]            instr_compressed_i,
  input  logic                   instr_is_compressed_i,
  input  logic [XLEN-1:0]        pc_id_i,
  input  logic [XLEN-1:0]        lsu_addr_last_i,
  input  logic                   in_flush_i,
  output logic                   special_req_o,
  output logic                   exc_pending_o,
  output logic                   mret_insn_o,
  output logic                   wfi_insn_o,
  output exc_cause_e             exc_cause_o,
  output logic [XLEN-1:0]        exc_mtval_o
);

  logic illegal_insn, ecall_insn, ebrk_insn, csr_pipe_flush, instr_fetch_err;
  logic illegal_mode;
  logic illegal_insn_d, illegal_insn_q;
  logic exc_req_d, exc_req_q;
  logic load_err_q, store_err_q;

  // decoder flags carry no valid of their own
  assign illegal_insn    = illegal_insn_i    & instr_valid_i;
  assign ecall_insn      = ecall_insn_i      & instr_valid_i;
  assign ebrk_insn       = ebrk_insn_i       & instr_valid_i;
  assign mret_insn_o     = mret_insn_i       & instr_valid_i;
  assign wfi_insn_o      = wfi_insn_i        & instr_valid_i;
  assign csr_pipe_flush  = csr_pipe_flush_i  & instr_valid_i;
  assign instr_fetch_err = instr_fetch_err_i & instr_valid_i;

  // MRET below M-mode, or WFI trapped by mstatus.TW
  assign illegal_mode = (priv_mode_i != PRIV_LVL_M) &
                        (mret_insn_o | (csr_mstatus_tw_i & wfi_insn_o));

  // requests drop while the FSM flushes so a handled one is not seen twice
  assign illegal_insn_d = (illegal_insn | illegal_mode) & ~in_flush_i;
  assign exc_req_d      = (ecall_insn | ebrk_insn | illegal_insn_d | instr_fetch_err) &
                          ~in_flush_i;

  // anything that needs the FSM to leave DECODE
  // LSU errors come from writeback and have no ID valid
  assign special_req_o = exc_req_d | load_err_i | store_err_i |
                         mret_insn_o | wfi_insn_o | csr_pipe_flush;

  assign exc_pending_o = exc_req_q | load_err_q | store_err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_insn_q <= 1'b0;
      exc_req_q      <= 1'b0;
      load_err_q     <= 1'b0;
      store_err_q    <= 1'b0;
    end else begin
      illegal_insn_q <= illegal_insn_d;
      exc_req_q      <= exc_req_d;
      load_err_q     <= load_err_i  & ~in_flush_i;
      store_err_q    <= store_err_i & ~in_flush_i;
    end
  end

  //////////////////////////////
  // priority and cause
  //////////////////////////////

  // fetch error ranks first, load error last
  // the ID stage still holds its instruction in FLUSH
  always_comb begin
    exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
    exc_mtval_o = '0;
    if (instr_fetch_err) begin
      exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // fault on the upper half of an unaligned word
      exc_mtval_o = instr_fetch_err_plus2_i ? (pc_id_i + XLEN'(2)) : pc_id_i;
    end else if (illegal_insn_q) begin
      exc_cause_o = EXC_CAUSE_ILLEGAL_INSN;
      exc_mtval_o = instr_is_compressed_i ? {{(XLEN-16){1'b0}}, instr_compressed_i} : instr_i;
    end else if (ecall_insn) begin
      exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_insn) begin
      // no debug mode, so every EBREAK is a breakpoint trap
      exc_cause_o = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc_cause_o = EXC_CAUSE_STORE_ACCESS_FAULT;
      exc_mtval_o = lsu_addr_last_i;
    end else if (load_err_q) begin
      exc_cause_o = EXC_CAUSE_LOAD_ACCESS_FAULT;
      exc_mtval_o = lsu_addr_last_i;
    end
  end

endmodule

/* hdl/core_ctrl_irq.sv */
//////////////////////////////
// interrupt decision, cause encoding
// and NMI mode flag
//////////////////////////////

`timescale 1ns/1ps

module core_ctrl_irq import core_ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    irq_nm_i,
  input  logic                    irq_pending_i,
  input  logic                    csr_mstatus_mie_i,
  input  logic                    irq_software_i,
  input  logic                    irq_timer_i,
  input  logic                    irq_external_i,
  input  logic [NUM_FAST_IRQ-1:0] irq_fast_i,
  input  logic                    irq_take_i,
  input  logic                    nmi_exit_i,
  output logic                    handle_irq_o,
  output exc_cause_e              irq_cause_o,
  output logic                    nmi_mode_o
);

  logic [FAST_ID_W-1:0] fast_id;
  logic                 nmi_mode_q;

  // nested NMIs are not supported and NMI cannot be preempted
  assign handle_irq_o = ~nmi_mode_q & (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));

  // lowest index wins among the fast lines
  always_comb begin
    fast_id = '0;
    for (int i = NUM_FAST_IRQ - 1; i >= 0; i--) begin
      if (irq_fast_i[i]) begin
        fast_id = i[FAST_ID_W-1:0];
      end
    end
  end

  // NMI, fast, external, software, timer
  always_comb begin
    irq_cause_o = EXC_CAUSE_IRQ_NM;
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (|irq_fast_i) begin
      // interrupt flag plus 16 on top of the index gives 0x30 + n
      irq_cause_o = exc_cause_e'({2'b11, fast_id});
    end else if (irq_external_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irq_software_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irq_timer_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // set on entry to the NMI handler, cleared by its MRET
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (irq_take_i && irq_nm_i) begin
      nmi_mode_q <= 1'b1;
    end else if (nmi_exit_i) begin
      nmi_mode_q <= 1'b0;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

endmodule

/* hdl/core_ctrl_fsm.sv */
//////////////////////////////
// controller FSM: boot, decode, flush,
// sleep and interrupt entry, stall control
//////////////////////////////

`timescale 1ns/1ps

module core_ctrl_fsm import core_ctrl_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_enable_i,
  input  logic            instr_valid_i,
  input  logic            stall_id_i,
  input  logic            branch_set_i,
  input  logic            jump_set_i,
  input  logic            irq_nm_i,
  input  logic            irq_pending_i,
  input  logic            special_req_i,
  input  logic            exc_pending_i,
  input  logic            mret_insn_i,
  input  logic            wfi_insn_i,
  input  exc_cause_e      exc_cause_i,
  input  logic [XLEN-1:0] exc_mtval_i,
  input  logic            handle_irq_i,
  input  exc_cause_e      irq_cause_i,
  input  logic            nmi_mode_i,
  output logic            ctrl_busy_o,
  output logic            controller_run_o,
  output logic            instr_req_o,
  output logic            pc_set_o,
  output pc_sel_e         pc_mux_o,
  output exc_cause_e      exc_cause_o,
  output logic [XLEN-1:0] csr_mtval_o,
  output logic            csr_save_if_o,
  output logic            csr_save_id_o,
  output logic            csr_save_cause_o,
  output logic            csr_restore_mret_o,
  output logic            id_in_ready_o,
  output logic            instr_valid_clear_o,
  output logic            flush_id_o,
  output logic            in_flush_o,
  output logic            irq_take_o,
  output logic            nmi_exit_o
);

  ctrl_state_e state_q, state_d;
  logic        halt_if;
  logic        retain_id;
  logic        flush_id;

  always_comb begin
    state_d            = state_q;
    instr_req_o        = 1'b1;
    ctrl_busy_o        = 1'b1;
    controller_run_o   = 1'b0;
    // pc_mux only matters while pc_set is high
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_cause_o        = exc_cause_i;
    csr_mtval_o        = '0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    halt_if            = 1'b0;
    retain_id          = 1'b0;
    flush_id           = 1'b0;
    irq_take_o         = 1'b0;
    nmi_exit_o         = 1'b0;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        // load the boot address into the fetch PC
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // any interrupt wakes the core, even with MIE clear
        if (irq_nm_i || irq_pending_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for the first instruction to be accepted
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        if (handle_irq_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        pc_mux_o         = PC_JUMP;
        // keep the instruction in ID so FLUSH can see it
        if (special_req_i) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        if (branch_set_i || jump_set_i) begin
          pc_set_o = 1'b1;
        end
        // let the instruction in ID finish before the interrupt
        if (handle_irq_i && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end
        if (!stall_id_i && !special_req_i && !instr_valid_i && handle_irq_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end

      IRQ_TAKEN: begin
        pc_mux_o = PC_EXC;
        // mepc takes the IF PC since ID is empty
        if (handle_irq_i) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq_cause_i;
          irq_take_o       = 1'b1;
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc_pending_i) begin
          // trap, mepc takes the ID PC
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          csr_mtval_o      = exc_mtval_i;
        end else if (mret_insn_i) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_restore_mret_o = 1'b1;
          nmi_exit_o         = nmi_mode_i;
        end else if (wfi_insn_i) begin
          state_d = WAIT_SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // stall control
  //////////////////////////////

  assign id_in_ready_o       = ~stall_id_i & ~halt_if & ~retain_id;
  // retain keeps valid set unless the flush kills it
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;
  assign flush_id_o          = flush_id;
  assign in_flush_o          = (state_q == FLUSH);

endmodule

/* hdl/core_ctrl.sv */
//////////////////////////////
// controller top: exception, interrupt
// and FSM units
//////////////////////////////

`timescale 1ns/1ps

module core_ctrl import core_ctrl_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_enable_i,
  output logic                    ctrl_busy_o,
  output logic                    controller_run_o,
  // decoder
  input  logic                    illegal_insn_i,
  input  logic                    ecall_insn_i,
  input  logic                    ebrk_insn_i,
  input  logic                    mret_insn_i,
  input  logic                    wfi_insn_i,
  input  logic                    csr_pipe_flush_i,
  // IF-ID register
  input  logic                    instr_valid_i,
  input  logic [XLEN-1:0]         instr_i,
  input  logic [15:0]             instr_compressed_i,
  input  logic                    instr_is_compressed_i,
  input  logic                    instr_fetch_err_i,
  input  logic                    instr_fetch_err_plus2_i,
  input  logic [XLEN-1:0]         pc_id_i,
  output logic                    instr_valid_clear_o,
  output logic                    id_in_ready_o,
  // fetch
  output logic                    instr_req_o,
  output logic                    pc_set_o,
  output pc_sel_e                 pc_mux_o,
  output exc_cause_e              exc_cause_o,
  // LSU
  input  logic [XLEN-1:0]         lsu_addr_last_i,
  input  logic                    load_err_i,
  input  logic                    store_err_i,
  input  logic                    branch_set_i,
  input  logic                    jump_set_i,
  // interrupts
  input  logic                    csr_mstatus_mie_i,
  input  logic                    irq_pending_i,
  input  logic                    irq_software_i,
  input  logic                    irq_timer_i,
  input  logic                    irq_external_i,
  input  logic [NUM_FAST_IRQ-1:0] irq_fast_i,
  input  logic                    irq_nm_i,
  output logic                    nmi_mode_o,
  // CSR file
  output logic                    csr_save_if_o,
  output logic                    csr_save_id_o,
  output logic                    csr_restore_mret_o,
  output logic                    csr_save_cause_o,
  output logic [XLEN-1:0]         csr_mtval_o,
  input  priv_lvl_e               priv_mode_i,
  input  logic                    csr_mstatus_tw_i,
  // pipeline
  input  logic                    stall_id_i,
  output logic                    flush_id_o
);

  logic            special_req, exc_pending, mret_insn, wfi_insn, in_flush;
  exc_cause_e      exc_cause, irq_cause;
  logic [XLEN-1:0] exc_mtval;
  logic            handle_irq, irq_take, nmi_exit;

  core_ctrl_exc u_exc (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .instr_valid_i           (instr_valid_i),
    .illegal_insn_i          (illegal_insn_i),
    .ecall_insn_i            (ecall_insn_i),
    .ebrk_insn_i             (ebrk_insn_i),
    .mret_insn_i             (mret_insn_i),
    .wfi_insn_i              (wfi_insn_i),
    .csr_pipe_flush_i        (csr_pipe_flush_i),
    .instr_fetch_err_i       (instr_fetch_err_i),
    .instr_fetch_err_plus2_i (instr_fetch_err_plus2_i),
    .priv_mode_i             (priv_mode_i),
    .csr_mstatus_tw_i        (csr_mstatus_tw_i),
    .load_err_i              (load_err_i),
    .store_err_i             (store_err_i),
    .instr_i                 (instr_i),
    .instr_compressed_i      (instr_compressed_i),
    .instr_is_compressed_i   (instr_is_compressed_i),
    .pc_id_i                 (pc_id_i),
    .lsu_addr_last_i         (lsu_addr_last_i),
    .in_flush_i              (in_flush),
    .special_req_o           (special_req),
    .exc_pending_o           (exc_pending),
    .mret_insn_o             (mret_insn),
    .wfi_insn_o              (wfi_insn),
    .exc_cause_o             (exc_cause),
    .exc_mtval_o             (exc_mtval)
  );

  core_ctrl_irq u_irq (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .irq_nm_i          (irq_nm_i),
    .irq_pending_i     (irq_pending_i),
    .csr_mstatus_mie_i (csr_mstatus_mie_i),
    .irq_software_i    (irq_software_i),
    .irq_timer_i       (irq_timer_i),
    .irq_external_i    (irq_external_i),
    .irq_fast_i        (irq_fast_i),
    .irq_take_i        (irq_take),
    .nmi_exit_i        (nmi_exit),
    .handle_irq_o      (handle_irq),
    .irq_cause_o       (irq_cause),
    .nmi_mode_o        (nmi_mode_o)
  );

  core_ctrl_fsm u_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .instr_valid_i       (instr_valid_i),
    .stall_id_i          (stall_id_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .irq_nm_i            (irq_nm_i),
    .irq_pending_i       (irq_pending_i),
    .special_req_i       (special_req),
    .exc_pending_i       (exc_pending),
    .mret_insn_i         (mret_insn),
    .wfi_insn_i          (wfi_insn),
    .exc_cause_i         (exc_cause),
    .exc_mtval_i         (exc_mtval),
    .handle_irq_i        (handle_irq),
    .irq_cause_i         (irq_cause),
    .nmi_mode_i          (nmi_mode_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .controller_run_o    (controller_run_o),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_cause_o         (exc_cause_o),
    .csr_mtval_o         (csr_mtval_o),
    .csr_save_if_o       (csr_save_if_o),
    .csr_save_id_o       (csr_save_id_o),
    .csr_save_cause_o    (csr_save_cause_o),
    .csr_restore_mret_o  (csr_restore_mret_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .in_flush_o          (in_flush),
    .irq_take_o          (irq_take),
    .nmi_exit_o          (nmi_exit)
  );

endmodule

/* test/core_ctrl_tb_tasks.svh */
//////////////////////////////
// testbench helpers: xorshift, compare
// tasks, input drive and directed tests
//////////////////////////////

`ifndef CORE_CTRL_TB_TASKS_SVH
`define CORE_CTRL_TB_TASKS_SVH

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] v;
  v = x;
  v = v ^ (v << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic report_error(input string msg);
  $display("%0t: %s", $time, msg);
  $display("test failed");
  $fatal(1);
endtask

task automatic check_bit(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    $display("[FAIL] %0t %s: got %b, expected %b", $time, name, act, exp);
    $display("test failed");
    $fatal(1);
  end
endtask

task automatic check_word(input string name, input logic [XLEN-1:0] act,
                          input logic [XLEN-1:0] exp);
  if (act !== exp) begin
    $display("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp);
    $display("test failed");
    $fatal(1);
  end
endtask

task automatic check_cause(input string name, input exc_cause_e act, input exc_cause_e exp);
  if (act !== exp) begin
    $display("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp);
    $display("test failed");
    $fatal(1);
  end
endtask

task automatic check_pc_sel(input string name, input pc_sel_e act, input pc_sel_e exp);
  if (act !== exp) begin
    $display("[FAIL] %0t %s: got %h, expected %h", $time, name, act, exp);
    $display("test failed");
    $fatal(1);
  end
endtask

//////////////////////////////
// drive helpers
//////////////////////////////

// return the ID stage and interrupt lines to idle
task automatic clear_inputs();
  instr_valid_i           = 1'b0;
  illegal_insn_i          = 1'b0;
  ecall_insn_i            = 1'b0;
  ebrk_insn_i             = 1'b0;
  mret_insn_i             = 1'b0;
  wfi_insn_i              = 1'b0;
  csr_pipe_flush_i        = 1'b0;
  instr_fetch_err_i       = 1'b0;
  instr_fetch_err_plus2_i = 1'b0;
  instr_is_compressed_i   = 1'b0;
  load_err_i              = 1'b0;
  store_err_i             = 1'b0;
  branch_set_i            = 1'b0;
  jump_set_i              = 1'b0;
  stall_id_i              = 1'b0;
  irq_nm_i                = 1'b0;
  irq_pending_i           = 1'b0;
  irq_software_i          = 1'b0;
  irq_timer_i             = 1'b0;
  irq_external_i          = 1'b0;
  irq_fast_i              = '0;
endtask

// request driven in DECODE, trap expected in the FLUSH cycle after it
task automatic expect_trap(input exc_cause_e cause, input logic [XLEN-1:0] mtval);
  @(negedge clk_i);
  check_bit("pc_set_o", pc_set_o, 1'b1);
  check_pc_sel("pc_mux_o", pc_mux_o, PC_EXC);
  check_bit("csr_save_cause_o", csr_save_cause_o, 1'b1);
  check_bit("csr_save_id_o", csr_save_id_o, 1'b1);
  check_bit("flush_id_o", flush_id_o, 1'b1);
  check_cause("exc_cause_o", exc_cause_o, cause);
  check_word("csr_mtval_o", csr_mtval_o, mtval);
  // ID stage lets go of its instruction on the edge that ends FLUSH
  @(negedge clk_i);
  clear_inputs();
endtask

// expected interrupt cause from the priority rule
function automatic exc_cause_e expected_irq_cause(input logic nm, input logic sw,
                                                  input logic tmr, input logic ext,
                                                  input logic [NUM_FAST_IRQ-1:0] fast);
  exc_cause_e c;
  logic       found;
  c     = EXC_CAUSE_IRQ_NM;
  found = 1'b0;
  for (int i = 0; i < NUM_FAST_IRQ; i++) begin
    if (fast[i] && !found) begin
      c     = exc_cause_e'(6'h30 + 6'(i));
      found = 1'b1;
    end
  end
  if (nm) begin
    c = EXC_CAUSE_IRQ_NM;
  end else if (!found) begin
    if (ext) begin
      c = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (sw) begin
      c = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (tmr) begin
      c = EXC_CAUSE_IRQ_TIMER_M;
    end
  end
  return c;
endfunction

// raise interrupt lines in idle DECODE and check the IRQ_TAKEN cycle
task automatic take_irq(input logic nm, input logic sw, input logic tmr, input logic ext,
                        input logic [NUM_FAST_IRQ-1:0] fast);
  irq_nm_i       = nm;
  irq_pending_i  = sw | tmr | ext | (|fast);
  irq_software_i = sw;
  irq_timer_i    = tmr;
  irq_external_i = ext;
  irq_fast_i     = fast;
  @(negedge clk_i);
  check_bit("pc_set_o", pc_set_o, 1'b1);
  check_pc_sel("pc_mux_o", pc_mux_o, PC_EXC);
  check_bit("csr_save_if_o", csr_save_if_o, 1'b1);
  check_bit("csr_save_cause_o", csr_save_cause_o, 1'b1);
  check_cause("exc_cause_o", exc_cause_o, expected_irq_cause(nm, sw, tmr, ext, fast));
  // lines stay up until the handler entry edge
  @(negedge clk_i);
  clear_inputs();
endtask

`endif

/* test/core_ctrl_tb.sv */
//////////////////////////////
// controller testbench: clock, reset,
// DUT, watchdog and directed tests
//////////////////////////////

`timescale 1ns/1ps

module core_ctrl_tb import core_ctrl_pkg::*; ();

  localparam int NUM_TESTS = 6;

  logic clk_i, rst_ni, fetch_enable_i, ctrl_busy_o, controller_run_o;
  logic illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, wfi_insn_i;
  logic csr_pipe_flush_i, instr_valid_i, instr_is_compressed_i;
  logic instr_fetch_err_i, instr_fetch_err_plus2_i;
  logic [XLEN-1:0] instr_i, pc_id_i, lsu_addr_last_i, csr_mtval_o;
  logic [15:0] instr_compressed_i;
  logic instr_valid_clear_o, id_in_ready_o, instr_req_o, pc_set_o;
  pc_sel_e pc_mux_o;
  exc_cause_e exc_cause_o;
  logic load_err_i, store_err_i, branch_set_i, jump_set_i;
  logic csr_mstatus_mie_i, irq_pending_i, irq_software_i, irq_timer_i, irq_external_i;
  logic [NUM_FAST_IRQ-1:0] irq_fast_i;
  logic irq_nm_i, nmi_mode_o;
  logic csr_save_if_o, csr_save_id_o, csr_restore_mret_o, csr_save_cause_o;
  priv_lvl_e priv_mode_i;
  logic csr_mstatus_tw_i, stall_id_i, flush_id_o;
  logic [31:0] rng_state;

  core_ctrl core_ctrl_inst (.*);

  `include "core_ctrl_tb_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // bound on the whole run
  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("%0t: watchdog expired, the tests did not complete", $time);
    $display("test failed");
    $fatal(1);
  end

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_boot();
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_sel("pc_mux_o", pc_mux_o, PC_BOOT);
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    // BOOT_SET
    check_bit("instr_req_o", instr_req_o, 1'b1);
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_sel("pc_mux_o", pc_mux_o, PC_BOOT);
    // FIRST_FETCH then DECODE
    repeat (2) @(negedge clk_i);
    check_bit("controller_run_o", controller_run_o, 1'b1);
  endtask

  task automatic test_single_exc();
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] word;
    pc = next_rand() & ~32'h1;
    word = next_rand();
    pc_id_i = pc;
    instr_i = word;
    instr_compressed_i = word[31:16];
    // fetch error, aligned and on the upper half
    instr_valid_i = 1'b1;
    instr_fetch_err_i = 1'b1;
    expect_trap(EXC_CAUSE_INSTR_ACCESS_FAULT, pc);
    instr_valid_i = 1'b1;
    instr_fetch_err_i = 1'b1;
    instr_fetch_err_plus2_i = 1'b1;
    expect_trap(EXC_CAUSE_INSTR_ACCESS_FAULT, pc + 32'd2);
    // illegal, full width and compressed
    instr_valid_i = 1'b1;
    illegal_insn_i = 1'b1;
    expect_trap(EXC_CAUSE_ILLEGAL_INSN, word);
    instr_valid_i = 1'b1;
    illegal_insn_i = 1'b1;
    instr_is_compressed_i = 1'b1;
    expect_trap(EXC_CAUSE_ILLEGAL_INSN, {16'h0, word[31:16]});
    instr_valid_i = 1'b1;
    ecall_insn_i = 1'b1;
    expect_trap(EXC_CAUSE_ECALL_MMODE, '0);
    priv_mode_i = PRIV_LVL_U;
    instr_valid_i = 1'b1;
    ecall_insn_i = 1'b1;
    expect_trap(EXC_CAUSE_ECALL_UMODE, '0);
    // WFI trapped by TW below M-mode
    csr_mstatus_tw_i = 1'b1;
    instr_valid_i = 1'b1;
    wfi_insn_i = 1'b1;
    expect_trap(EXC_CAUSE_ILLEGAL_INSN, word);
    csr_mstatus_tw_i = 1'b0;
    priv_mode_i = PRIV_LVL_M;
    instr_valid_i = 1'b1;
    ebrk_insn_i = 1'b1;
    expect_trap(EXC_CAUSE_BREAKPOINT, '0);
    lsu_addr_last_i = next_rand();
    store_err_i = 1'b1;
    expect_trap(EXC_CAUSE_STORE_ACCESS_FAULT, lsu_addr_last_i);
    load_err_i = 1'b1;
    expect_trap(EXC_CAUSE_LOAD_ACCESS_FAULT, lsu_addr_last_i);
  endtask

  task automatic test_priority();
    pc_id_i = next_rand() & ~32'h1;
    instr_i = next_rand();
    lsu_addr_last_i = next_rand();
    for (int round = 0; round < 4; round++) begin
      instr_valid_i = 1'b1;
      instr_fetch_err_i = (round < 1);
      illegal_insn_i = (round < 2);
      ecall_insn_i = (round < 3);
      load_err_i = 1'b1;
      case (round)
        0: expect_trap(EXC_CAUSE_INSTR_ACCESS_FAULT, pc_id_i);
        1: expect_trap(EXC_CAUSE_ILLEGAL_INSN, instr_i);
        2: expect_trap(EXC_CAUSE_ECALL_MMODE, '0);
        default: expect_trap(EXC_CAUSE_LOAD_ACCESS_FAULT, lsu_addr_last_i);
      endcase
    end
  endtask

  task automatic test_irq();
    csr_mstatus_mie_i = 1'b1;
    take_irq(1'b0, 1'b0, 1'b1, 1'b1, 15'h0220);
    take_irq(1'b0, 1'b1, 1'b1, 1'b1, 15'h0);
    take_irq(1'b0, 1'b1, 1'b1, 1'b0, 15'h0);
    take_irq(1'b0, 1'b0, 1'b1, 1'b0, 15'h0);
    take_irq(1'b0, 1'b1, 1'b0, 1'b1, 15'(next_rand() | 32'h4000));
    take_irq(1'b1, 1'b1, 1'b0, 1'b1, 15'h0001);
    check_bit("nmi_mode_o", nmi_mode_o, 1'b1);
    instr_valid_i = 1'b1;
    mret_insn_i = 1'b1;
    @(negedge clk_i);
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_sel("pc_mux_o", pc_mux_o, PC_ERET);
    check_bit("csr_restore_mret_o", csr_restore_mret_o, 1'b1);
    // MRET stays in ID until the edge that ends FLUSH
    @(negedge clk_i);
    clear_inputs();
    check_bit("nmi_mode_o", nmi_mode_o, 1'b0);
    csr_mstatus_mie_i = 1'b0;
  endtask

  task automatic test_sleep();
    int waited;
    instr_valid_i = 1'b1;
    wfi_insn_i = 1'b1;
    @(negedge clk_i);
    // FLUSH, WFI is still held in ID for the whole cycle
    check_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b1);
    waited = 0;
    while (ctrl_busy_o && waited < 2) begin
      @(negedge clk_i);
      waited++;
    end
    clear_inputs();
    if (ctrl_busy_o) report_error("ctrl_busy_o did not drop within two cycles of WFI");
    repeat (3) begin
      @(negedge clk_i);
      check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
    end
    irq_pending_i = 1'b1;
    #1;
    check_bit("ctrl_busy_o", ctrl_busy_o, 1'b1);
    @(negedge clk_i);
    irq_pending_i = 1'b0;
    @(negedge clk_i);
    check_bit("controller_run_o", controller_run_o, 1'b1);
  endtask

  task automatic test_stall_branch();
    stall_id_i = 1'b1;
    instr_valid_i = 1'b1;
    repeat (3) begin
      #1;
      check_bit("id_in_ready_o", id_in_ready_o, 1'b0);
      check_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b0);
      check_bit("controller_run_o", controller_run_o, 1'b1);
      @(negedge clk_i);
    end
    stall_id_i = 1'b0;
    branch_set_i = 1'b1;
    #1;
    check_bit("pc_set_o", pc_set_o, 1'b1);
    check_pc_sel("pc_mux_o", pc_mux_o, PC_JUMP);
    check_bit("id_in_ready_o", id_in_ready_o, 1'b1);
    check_bit("flush_id_o", flush_id_o, 1'b0);
    @(negedge clk_i);
    clear_inputs();
  endtask

  initial begin
    rng_state = 32'he2a4;
    rst_ni = 1'b0;
    fetch_enable_i = 1'b0;
    priv_mode_i = PRIV_LVL_M;
    csr_mstatus_tw_i = 1'b0;
    csr_mstatus_mie_i = 1'b0;
    instr_i = '0;
    instr_compressed_i = '0;
    pc_id_i = '0;
    lsu_addr_last_i = '0;
    clear_inputs();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_boot();
    test_single_exc();
    test_priority();
    test_irq();
    test_sleep();
    test_stall_branch();
    $display("test passed");
    $finish;
  end

endmodule

/* core_ctrl.f */
+incdir+test
hdl/core_ctrl_pkg.sv
hdl/core_ctrl_exc.sv
hdl/core_ctrl_irq.sv
hdl/core_ctrl_fsm.sv
hdl/core_ctrl.sv
test/core_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f core_ctrl.f --top-module core_ctrl_tb -o core_ctrl_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/core_ctrl_sim > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  exit 1
fi
if [ $RUN_STATUS -ne 0 ]; then
  echo "simulation exited with status $RUN_STATUS"
  exit 1
fi
exit 0
